//--- all.f
hw/silencer_pkg.sv
hw/silencer_dispatch.sv
hw/silencer_lane.sv
hw/silencer_collect.sv
hw/silencer_top.sv
testbench/tb_clock.sv
testbench/tb_silencer.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_silencer \
	  -f all.f -o Vtb_silencer

run: build
	./obj_dir/Vtb_silencer 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG) || \
	  { echo "no result line in $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --top-module silencer_top \
	  hw/silencer_pkg.sv hw/silencer_dispatch.sv hw/silencer_lane.sv \
	  hw/silencer_collect.sv hw/silencer_top.sv

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_silencer.sv
// Testbench for silencer_top with a reference model, a credit source and a credit sink.
// Inputs change on the falling edge and assertions sample on the rising edge.
// Steps are changed only while the DUT is drained.
// Frames are always queued whole, so sample n of a frame is transducer n.

module tb_silencer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 4000;

  logic                     CLK;
  logic                     arst_n;
  logic                     in_valid = 1'b0;
  silencer_pkg::intensity_t in_intensity = '0;
  silencer_pkg::phase_t     in_phase = '0;
  logic                     in_credit;
  silencer_pkg::step_t      step_intensity = 16'hFFFF;
  silencer_pkg::step_t      step_phase = 16'hFFFF;
  logic                     out_valid;
  silencer_pkg::index_t     out_index;
  silencer_pkg::intensity_t out_intensity;
  silencer_pkg::phase_t     out_phase;
  logic                     out_credit = 1'b0;

  int model_int [silencer_pkg::NUM_TRANSDUCERS] = '{default: 0};
  int model_ph [silencer_pkg::NUM_TRANSDUCERS] = '{default: 0};  // Fine phase.
  logic [23:0] tx_q [$];  // Intensity and phase still to send.
  int exp_idx_q [$];
  int exp_int_q [$];
  int exp_ph_q [$];

  int src_credits = silencer_pkg::IN_FIFO_DEPTH;
  int samples_sent = 0;
  int credit_pulses = 0;
  int send_idx = 0;
  int sink_avail = silencer_pkg::OUT_CREDITS;
  int sink_held = 0;
  int sink_delay = 0;
  int received = 0;
  int exp_index = 0;
  int exp_intensity = 0;
  int exp_phase = 0;
  logic extra_output = 1'b0;
  logic hold_sink = 1'b0;
  logic random_delay = 1'b0;
  logic idle_check = 1'b1;
  logic timed_out = 1'b0;
  logic [31:0] lfsr = 32'h9b1beca9;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_start_errors = 0;

  tb_clock clock_gen (.CLK(CLK), .arst_n(arst_n));

  silencer_top DUT (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_intensity   (in_intensity),
    .in_phase       (in_phase),
    .in_credit      (in_credit),
    .step_intensity (step_intensity),
    .step_phase     (step_phase),
    .out_valid      (out_valid),
    .out_index      (out_index),
    .out_intensity  (out_intensity),
    .out_phase      (out_phase),
    .out_credit     (out_credit)
  );

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int limit_delta(input int d, input int lim);
    if (d > lim) begin
      return lim;
    end
    if (d < -lim) begin
      return -lim;
    end
    return d;
  endfunction

  // One slew step for transducer n with the result queued as expected output.
  task automatic apply_model(input int n, input logic [15:0] t_int, input logic [7:0] t_ph);
    int d;
    d = int'(t_int) - model_int[n];
    model_int[n] = model_int[n] + limit_delta(d, int'(step_intensity));
    d = int'(t_ph) * 256 - model_ph[n];
    if (d > 32768) begin
      d = d - 65536;  // Shorter way around.
    end else if (d < -32768) begin
      d = d + 65536;
    end
    model_ph[n] = (model_ph[n] + limit_delta(d, int'(step_phase)) + 65536) % 65536;
    exp_idx_q.push_back(n);
    exp_int_q.push_back(model_int[n]);
    exp_ph_q.push_back(model_ph[n] / 256);
  endtask

  // Source side. Credit is checked before this cycle's pulse is counted.
  always @(negedge CLK) begin : source_drive
    logic [23:0] s;
    in_valid = 1'b0;
    if (arst_n === 1'b1 && tx_q.size() > 0 && src_credits > 0) begin
      s = tx_q.pop_front();
      in_valid = 1'b1;
      in_intensity = s[23:8];
      in_phase = s[7:0];
      src_credits--;
      samples_sent++;
      apply_model(send_idx, s[23:8], s[7:0]);
      send_idx = (send_idx + 1) % silencer_pkg::NUM_TRANSDUCERS;
    end
    if (arst_n === 1'b1 && in_credit === 1'b1) begin
      credit_pulses++;
      src_credits++;
    end
  end

  // Sink side. One credit goes back per held output after an optional delay.
  always @(negedge CLK) begin : sink_drive
    out_credit = 1'b0;
    if (arst_n === 1'b1 && out_valid === 1'b1) begin
      received++;
      sink_avail--;
      sink_held++;
      extra_output = (exp_idx_q.size() == 0);
      if (!extra_output) begin
        exp_index = exp_idx_q.pop_front();
        exp_intensity = exp_int_q.pop_front();
        exp_phase = exp_ph_q.pop_front();
      end
    end
    if (arst_n === 1'b1 && !hold_sink && sink_held > 0) begin
      if (sink_delay > 0) begin
        sink_delay--;
      end else begin
        out_credit = 1'b1;
        sink_held--;
        sink_avail++;
        sink_delay = random_delay ? int'(take_bits(2)) : 0;
      end
    end
  end

  assert property (@(posedge CLK) idle_check |-> !in_credit && !out_valid)
    else begin
      $display("in_credit or out_valid went high while the DUT was idle");
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n) out_valid |-> !extra_output)
    else begin
      $display("an output arrived with no sample outstanding");
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n)
                   out_valid && !extra_output |-> int'(out_index) == exp_index)
    else begin
      $display("mismatch out_index got %h expected %h", $sampled(out_index), exp_index);
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n)
                   out_valid && !extra_output |-> int'(out_intensity) == exp_intensity)
    else begin
      $display("mismatch out_intensity got %h expected %h", $sampled(out_intensity),
               exp_intensity);
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n)
                   out_valid && !extra_output |-> int'(out_phase) == exp_phase)
    else begin
      $display("mismatch out_phase got %h expected %h", $sampled(out_phase), exp_phase);
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n) sink_avail >= 0)
    else begin
      $display("the DUT sent more outputs than the sink granted credits");
      errors++;
    end
  assert property (@(posedge CLK) disable iff (!arst_n) credit_pulses <= samples_sent)
    else begin
      $display("in_credit pulsed more often than samples were sent");
      errors++;
    end

  task automatic push_sample(input logic [15:0] t_int, input logic [7:0] t_ph);
    tx_q.push_back({t_int, t_ph});
  endtask

  task automatic fixed_frames(input int frames, input int base_int, input int base_ph,
                              input int spread);
    for (int f = 0; f < frames; f++) begin
      for (int n = 0; n < silencer_pkg::NUM_TRANSDUCERS; n++) begin
        push_sample(16'(base_int + n * spread), 8'(base_ph + n * spread));
      end
    end
  endtask

  task automatic random_frames(input int frames);
    logic [15:0] t_int;
    logic [7:0] t_ph;
    for (int i = 0; i < frames * silencer_pkg::NUM_TRANSDUCERS; i++) begin
      t_int = 16'(take_bits(16));
      t_ph = 8'(take_bits(8));
      push_sample(t_int, t_ph);
    end
  endtask

  task automatic set_steps(input logic [15:0] si, input logic [15:0] sp);
    @(negedge CLK);
    step_intensity = si;
    step_phase = sp;
    @(posedge CLK);
  endtask

  task automatic await_reset();
    int waited;
    waited = 0;
    while (arst_n !== 1'b1 && !timed_out) begin
      @(posedge CLK);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: reset was never released");
      end
    end
  endtask

  task automatic drain_dut();
    int waited;
    waited = 0;
    while (!timed_out && (tx_q.size() != 0 || exp_idx_q.size() != 0 || sink_held != 0)) begin
      @(posedge CLK);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: %0d outputs still missing", exp_idx_q.size() + tx_q.size());
      end
    end
  endtask

  // Waits until neither in_credit nor out_valid has moved for 20 cycles.
  task automatic settle_stall();
    int waited;
    int still;
    int last_pulses;
    int last_rx;
    waited = 0;
    still = 0;
    last_pulses = credit_pulses;
    last_rx = received;
    while (still < 20 && !timed_out) begin
      @(posedge CLK);
      waited++;
      if (credit_pulses == last_pulses && received == last_rx) begin
        still++;
      end else begin
        still = 0;
        last_pulses = credit_pulses;
        last_rx = received;
      end
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: the DUT never stalled under back-pressure");
      end
    end
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != test_start_errors || timed_out) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - test_start_errors);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  initial begin
    int rx_start;
    start_test();
    await_reset();
    repeat (20) @(posedge CLK);
    @(negedge CLK);
    idle_check = 1'b0;
    @(posedge CLK);
    report_test("reset");

    start_test();
    set_steps(16'h0100, 16'hFFFF);
    fixed_frames(6, 16'h0480, 0, 4);  // Rise by the step and then settle.
    fixed_frames(5, 16'h0040, 0, 4);
    drain_dut();
    report_test("intensity slew");

    start_test();
    set_steps(16'hFFFF, 16'hFFFF);
    fixed_frames(1, 16'h1000, 250, 0);
    drain_dut();
    set_steps(16'hFFFF, 16'h0300);
    fixed_frames(5, 16'h1000, 4, 0);  // Forward through 255 to 0.
    fixed_frames(6, 16'h1000, 200, 0);  // Backward through 0.
    drain_dut();
    report_test("phase wrap");

    start_test();
    set_steps(16'hFFFF, 16'hFFFF);
    random_frames(2);
    drain_dut();
    report_test("unlimited step");

    start_test();
    set_steps(16'h2000, 16'h1000);
    hold_sink = 1'b1;
    rx_start = received;
    random_frames(2);
    settle_stall();
    assert (received - rx_start == silencer_pkg::OUT_CREDITS)
      else begin
        $display("mismatch outputs under back-pressure got %h expected %h",
                 received - rx_start, silencer_pkg::OUT_CREDITS);
        errors++;
      end
    assert (samples_sent - credit_pulses == silencer_pkg::IN_FIFO_DEPTH)
      else begin
        $display("mismatch unanswered samples got %h expected %h",
                 samples_sent - credit_pulses, silencer_pkg::IN_FIFO_DEPTH);
        errors++;
      end
    random_delay = 1'b1;
    hold_sink = 1'b0;
    drain_dut();
    random_delay = 1'b0;
    report_test("back-pressure");

    start_test();
    set_steps(16'h0800, 16'h0400);
    random_frames(3);
    drain_dut();
    assert (credit_pulses == samples_sent)
      else begin
        $display("mismatch in_credit pulses got %h expected %h", credit_pulses, samples_sent);
        errors++;
      end
    report_test("input credits");

    $display("summary: %0d tests, %0d failed, %0d errors, %0d outputs checked",
             tests_run, tests_failed, errors, received);
    if (tests_failed == 0 && errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock.sv
// Clock and reset source for the silencer testbench.
// CLK has a 10 ns period. arst_n is low from the start and is released
// on a falling edge after 16 rising edges.

module tb_clock (
  output logic CLK,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
  end

endmodule

//--- hw/silencer_top.sv
// Silencer top level. Frames run in index order with no frame-start trigger.
// The source starts with IN_FIFO_DEPTH credits, the sink grants OUT_CREDITS.
// step_intensity and step_phase must stay stable while frames run.

module silencer_top (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  silencer_pkg::intensity_t  in_intensity,
  input  silencer_pkg::phase_t      in_phase,
  output logic                      in_credit,
  input  silencer_pkg::step_t       step_intensity,
  input  silencer_pkg::step_t       step_phase,
  output logic                      out_valid,
  output silencer_pkg::index_t      out_index,
  output silencer_pkg::intensity_t  out_intensity,
  output silencer_pkg::phase_t      out_phase,
  input  logic                      out_credit
);

  logic [silencer_pkg::NUM_LANES-1:0] disp_valid;
  logic [silencer_pkg::NUM_LANES-1:0] disp_credit;
  silencer_pkg::intensity_t           disp_intensity;
  silencer_pkg::phase_fine_t          disp_phase;
  logic [silencer_pkg::NUM_LANES-1:0] res_valid;
  logic [silencer_pkg::NUM_LANES-1:0] res_credit;
  silencer_pkg::intensity_t           res_intensity [silencer_pkg::NUM_LANES];
  silencer_pkg::phase_t               res_phase [silencer_pkg::NUM_LANES];

  silencer_dispatch u_dispatch (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_intensity   (in_intensity),
    .in_phase       (in_phase),
    .lane_credit    (disp_credit),
    .in_credit      (in_credit),
    .lane_valid     (disp_valid),
    .lane_intensity (disp_intensity),
    .lane_phase     (disp_phase)
  );

  for (genvar i = 0; i < silencer_pkg::NUM_LANES; i++) begin : g_lane
    silencer_lane u_lane (
      .CLK            (CLK),
      .arst_n         (arst_n),
      .in_valid       (disp_valid[i]),
      .in_intensity   (disp_intensity),  // Shared bus, qualified per lane.
      .in_phase       (disp_phase),
      .step_intensity (step_intensity),
      .step_phase     (step_phase),
      .out_credit     (res_credit[i]),
      .in_credit      (disp_credit[i]),
      .out_valid      (res_valid[i]),
      .out_intensity  (res_intensity[i]),
      .out_phase      (res_phase[i])
    );
  end

  silencer_collect u_collect (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .lane_valid     (res_valid),
    .lane_intensity (res_intensity),
    .lane_phase     (res_phase),
    .out_credit     (out_credit),
    .lane_credit    (res_credit),
    .out_valid      (out_valid),
    .out_index      (out_index),
    .out_intensity  (out_intensity),
    .out_phase      (out_phase)
  );

endmodule

//--- hw/silencer_collect.sv
// Per-lane result buffers merged back into transducer order.
// Only the lane holding the next index is popped, so a late lane stalls all.
// out_index is the running index and wraps at NUM_TRANSDUCERS.

module silencer_collect (
  input  logic                               CLK,
  input  logic                               arst_n,
  input  logic [silencer_pkg::NUM_LANES-1:0] lane_valid,
  input  silencer_pkg::intensity_t           lane_intensity [silencer_pkg::NUM_LANES],
  input  silencer_pkg::phase_t               lane_phase [silencer_pkg::NUM_LANES],
  input  logic                               out_credit,
  output logic [silencer_pkg::NUM_LANES-1:0] lane_credit,
  output logic                               out_valid,
  output silencer_pkg::index_t               out_index,
  output silencer_pkg::intensity_t           out_intensity,
  output silencer_pkg::phase_t               out_phase
);

  typedef logic [$clog2(silencer_pkg::RESULT_DEPTH)-1:0] ptr_t;

  silencer_pkg::intensity_t
    res_intensity [silencer_pkg::NUM_LANES][silencer_pkg::RESULT_DEPTH];
  silencer_pkg::phase_t
    res_phase [silencer_pkg::NUM_LANES][silencer_pkg::RESULT_DEPTH];
  ptr_t                      wr_ptr [silencer_pkg::NUM_LANES];
  ptr_t                      rd_ptr [silencer_pkg::NUM_LANES];
  silencer_pkg::credit_t     fill [silencer_pkg::NUM_LANES];
  silencer_pkg::credit_t     sink_credits;
  silencer_pkg::index_t      idx;
  silencer_pkg::lane_index_t sel;
  logic                      pop;

  assign sel = silencer_pkg::lane_index_t'(idx % silencer_pkg::NUM_LANES);
  assign pop = (fill[sel] != '0) && (sink_credits != '0);

  always_comb begin
    for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
      lane_credit[i] = pop && (sel == silencer_pkg::lane_index_t'(i));
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
      if (lane_valid[i]) begin
        res_intensity[i][wr_ptr[i]] <= lane_intensity[i];
        res_phase[i][wr_ptr[i]] <= lane_phase[i];
      end
    end
    if (pop) begin
      out_index <= idx;
      out_intensity <= res_intensity[sel][rd_ptr[sel]];
      out_phase <= res_phase[sel][rd_ptr[sel]];
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        fill[i] <= '0;
      end
    end else begin
      for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
        if (lane_valid[i]) begin
          wr_ptr[i] <= wr_ptr[i] + 1'b1;
        end
        if (lane_credit[i]) begin
          rd_ptr[i] <= rd_ptr[i] + 1'b1;
        end
        case ({lane_valid[i], lane_credit[i]})
          2'b10:   fill[i] <= fill[i] + 1'b1;
          2'b01:   fill[i] <= fill[i] - 1'b1;
          default: fill[i] <= fill[i];
        endcase
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx <= '0;
      out_valid <= 1'b0;
      sink_credits <= silencer_pkg::credit_t'(silencer_pkg::OUT_CREDITS);
    end else begin
      out_valid <= pop;
      if (pop) begin
        if (idx == silencer_pkg::index_t'(silencer_pkg::NUM_TRANSDUCERS - 1)) begin
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
      case ({pop, out_credit})
        2'b10:   sink_credits <= sink_credits - 1'b1;
        2'b01:   sink_credits <= sink_credits + 1'b1;
        default: sink_credits <= sink_credits;
      endcase
    end
  end

endmodule

//--- hw/silencer_lane.sv
// One silencer lane for PER_LANE transducers, which are visited in slot order.
// A pop reserves an output credit, so the pipeline never stalls.
// Output follows a pop by exactly three cycles.
// No forwarding: a slot must not recur within three pops (PER_LANE > 3).

module silencer_lane (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  silencer_pkg::intensity_t  in_intensity,
  input  silencer_pkg::phase_fine_t in_phase,
  input  silencer_pkg::step_t       step_intensity,
  input  silencer_pkg::step_t       step_phase,
  input  logic                      out_credit,
  output logic                      in_credit,
  output logic                      out_valid,
  output silencer_pkg::intensity_t  out_intensity,
  output silencer_pkg::phase_t      out_phase
);

  typedef logic [$clog2(silencer_pkg::LANE_FIFO_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(silencer_pkg::PER_LANE)-1:0] slot_t;

  silencer_pkg::intensity_t  fifo_intensity [silencer_pkg::LANE_FIFO_DEPTH];
  silencer_pkg::phase_fine_t fifo_phase [silencer_pkg::LANE_FIFO_DEPTH];
  ptr_t                      wr_ptr;
  ptr_t                      rd_ptr;
  silencer_pkg::credit_t     fill;
  silencer_pkg::credit_t     credits;
  slot_t                     slot;
  logic                      pop;

  silencer_pkg::intensity_t  cur_intensity [silencer_pkg::PER_LANE];
  silencer_pkg::phase_fine_t cur_phase [silencer_pkg::PER_LANE];

  logic                      s1_valid;
  slot_t                     s1_slot;
  logic signed [17:0]        s1_cur_int;
  logic signed [17:0]        s1_cur_ph;
  logic signed [17:0]        s1_d_int;
  logic signed [17:0]        s1_d_ph;

  logic                      s2_valid;
  slot_t                     s2_slot;
  logic signed [17:0]        s2_cur_int;
  logic signed [17:0]        s2_cur_ph;
  logic signed [17:0]        s2_d_int;
  logic signed [17:0]        s2_d_ph;

  logic signed [17:0]        lim_int;
  logic signed [17:0]        lim_ph;
  logic signed [17:0]        d_ph_short;
  logic signed [17:0]        sum_int;
  logic signed [17:0]        sum_ph;
  silencer_pkg::intensity_t  next_int;
  silencer_pkg::phase_fine_t next_ph;

  function automatic logic signed [17:0] clamp(input logic signed [17:0] d,
                                               input logic signed [17:0] lim);
    if (d > lim) begin
      return lim;
    end else if (d < -lim) begin
      return -lim;
    end
    return d;
  endfunction

  assign pop = (fill != '0) && (credits != '0);
  assign in_credit = pop;

  assign lim_int = $signed({2'b00, step_intensity});
  assign lim_ph = $signed({2'b00, step_phase});

  // Take the shorter way around the circle.
  always_comb begin
    if (s1_d_ph > 18'sd32768) begin
      d_ph_short = s1_d_ph - 18'sd65536;
    end else if (s1_d_ph < -18'sd32768) begin
      d_ph_short = s1_d_ph + 18'sd65536;
    end else begin
      d_ph_short = s1_d_ph;
    end
  end

  assign sum_int = s2_cur_int + s2_d_int;
  assign sum_ph = s2_cur_ph + s2_d_ph;
  assign next_int = silencer_pkg::intensity_t'(sum_int);
  assign next_ph = silencer_pkg::phase_fine_t'(sum_ph);  // Modulo one period.

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      fifo_intensity[wr_ptr] <= in_intensity;
      fifo_phase[wr_ptr] <= in_phase;
    end
    s1_slot <= slot;
    s1_cur_int <= $signed({2'b00, cur_intensity[slot]});
    s1_cur_ph <= $signed({2'b00, cur_phase[slot]});
    s1_d_int <= $signed({2'b00, fifo_intensity[rd_ptr]} - {2'b00, cur_intensity[slot]});
    s1_d_ph <= $signed({2'b00, fifo_phase[rd_ptr]} - {2'b00, cur_phase[slot]});
    s2_slot <= s1_slot;
    s2_cur_int <= s1_cur_int;
    s2_cur_ph <= s1_cur_ph;
    s2_d_int <= clamp(s1_d_int, lim_int);
    s2_d_ph <= clamp(d_ph_short, lim_ph);
    if (s2_valid) begin
      out_intensity <= next_int;
      out_phase <= next_ph[15:8];
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      slot <= '0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        if (slot == slot_t'(silencer_pkg::PER_LANE - 1)) begin
          slot <= '0;
        end else begin
          slot <= slot + 1'b1;
        end
      end
      case ({in_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      s1_valid <= pop;
      s2_valid <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  // Transducer state, cleared to zero by reset.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < silencer_pkg::PER_LANE; i++) begin
        cur_intensity[i] <= '0;
        cur_phase[i] <= '0;
      end
    end else if (s2_valid) begin
      cur_intensity[s2_slot] <= next_int;
      cur_phase[s2_slot] <= next_ph;
    end
  end

  // Output credits toward the collector buffer.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      credits <= silencer_pkg::credit_t'(silencer_pkg::RESULT_DEPTH);
    end else begin
      case ({pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- hw/silencer_dispatch.sv
// Input buffer and lane router.
// The source must hold a credit for every in_valid. An overrun is not detected.
// Sample n goes to lane n modulo NUM_LANES, one sample per cycle at most.
// in_credit is combinational from state and pulses as the head sample leaves.

module silencer_dispatch (
  input  logic                               CLK,
  input  logic                               arst_n,
  input  logic                               in_valid,
  input  silencer_pkg::intensity_t           in_intensity,
  input  silencer_pkg::phase_t               in_phase,
  input  logic [silencer_pkg::NUM_LANES-1:0] lane_credit,
  output logic                               in_credit,
  output logic [silencer_pkg::NUM_LANES-1:0] lane_valid,
  output silencer_pkg::intensity_t           lane_intensity,
  output silencer_pkg::phase_fine_t          lane_phase
);

  typedef logic [$clog2(silencer_pkg::IN_FIFO_DEPTH)-1:0] ptr_t;

  silencer_pkg::intensity_t  buf_intensity [silencer_pkg::IN_FIFO_DEPTH];
  silencer_pkg::phase_t      buf_phase [silencer_pkg::IN_FIFO_DEPTH];
  ptr_t                      wr_ptr;
  ptr_t                      rd_ptr;
  silencer_pkg::credit_t     fill;
  silencer_pkg::credit_t     credits [silencer_pkg::NUM_LANES];
  silencer_pkg::index_t      idx;
  silencer_pkg::lane_index_t sel;
  logic                      pop;

  assign sel = silencer_pkg::lane_index_t'(idx % silencer_pkg::NUM_LANES);
  assign pop = (fill != '0) && (credits[sel] != '0);  // Head waits for its own lane.
  assign in_credit = pop;

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      buf_intensity[wr_ptr] <= in_intensity;
      buf_phase[wr_ptr] <= in_phase;
    end
    if (pop) begin
      lane_intensity <= buf_intensity[rd_ptr];
      lane_phase <= {buf_phase[rd_ptr], 8'h00};  // Widen to fine phase.
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      idx <= '0;
      lane_valid <= '0;
    end else begin
      lane_valid <= '0;
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        lane_valid[sel] <= 1'b1;
        if (idx == silencer_pkg::index_t'(silencer_pkg::NUM_TRANSDUCERS - 1)) begin
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
      case ({in_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // One credit counter per lane FIFO.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
        credits[i] <= silencer_pkg::credit_t'(silencer_pkg::LANE_FIFO_DEPTH);
      end
    end else begin
      for (int i = 0; i < silencer_pkg::NUM_LANES; i++) begin
        case ({pop && (sel == silencer_pkg::lane_index_t'(i)), lane_credit[i]})
          2'b10:   credits[i] <= credits[i] - 1'b1;
          2'b01:   credits[i] <= credits[i] + 1'b1;
          default: credits[i] <= credits[i];
        endcase
      end
    end
  end

endmodule

//--- hw/silencer_pkg.sv
// Shared sizes and types for the silencer and its testbench.
// NUM_TRANSDUCERS must be a multiple of NUM_LANES.
// All buffer depths must be powers of two, because FIFO pointers wrap naturally.

package silencer_pkg;

  localparam int NUM_TRANSDUCERS = 32;
  localparam int NUM_LANES = 4;
  localparam int PER_LANE = NUM_TRANSDUCERS / NUM_LANES;

  // Each depth is also the initial credit count of the link that feeds it.
  localparam int IN_FIFO_DEPTH = 4;
  localparam int LANE_FIFO_DEPTH = 4;
  localparam int RESULT_DEPTH = 4;
  localparam int OUT_CREDITS = 4;

  localparam int MAX_DEPTH_A = (IN_FIFO_DEPTH > LANE_FIFO_DEPTH) ?
                               IN_FIFO_DEPTH : LANE_FIFO_DEPTH;
  localparam int MAX_DEPTH_B = (RESULT_DEPTH > OUT_CREDITS) ? RESULT_DEPTH : OUT_CREDITS;
  localparam int MAX_DEPTH = (MAX_DEPTH_A > MAX_DEPTH_B) ? MAX_DEPTH_A : MAX_DEPTH_B;

  typedef logic [15:0] intensity_t;
  typedef logic [7:0] phase_t;          // Port phase, 256 per period.
  typedef logic [15:0] phase_fine_t;    // Internal phase, 65536 per period.
  typedef logic [15:0] step_t;

  typedef logic [$clog2(NUM_TRANSDUCERS)-1:0] index_t;
  typedef logic [$clog2(NUM_LANES)-1:0] lane_index_t;

  // Wide enough for any credit count or buffer fill level.
  typedef logic [$clog2(MAX_DEPTH + 1)-1:0] credit_t;

endpackage
